//--- Bender.yml
package:
  name: cga
  authors: []

sources:
  # Design, package first
  - files:
      - source/cga_pkg.sv
      - source/cga_int_unit.sv
      - source/cga_microword_decode.sv
      - source/cga_sequencer.sv
      - source/cga_top.sv

  # Simulation only
  - target: test
    files:
      - verification/cga_tb.sv

//--- all.f
source/cga_pkg.sv
source/cga_int_unit.sv
source/cga_microword_decode.sv
source/cga_sequencer.sv
source/cga_top.sv
verification/cga_tb.sv

//--- source/cga_int_unit.sv
// ----------------------------------------------------------
// CGA interrupt unit
// Takes the external interrupt lines on the ALU strobe, keeps
// pending and enable registers per level and encodes the
// highest pending and enabled level
// ----------------------------------------------------------
`timescale 1ns/1ps

module cga_int_unit (
  input  logic            sysclk,
  input  logic            rst_n,
  input  logic            aluclk,     // One strobe per microinstruction
  input  logic            ibint10_n,  // Level 10 line, active low
  input  logic            ibint11_n,  // Level 11
  input  logic            ibint12_n,  // Level 12
  input  logic            ibint13_n,  // Level 13
  input  logic            ibint15_n,  // Level 15
  input  logic [15:0]     cd,         // Command/data bus, enable source
  input  logic            pie_load,   // Copy cd into enable register
  input  logic            int_ack,    // Sequencer took a vector
  input  cga_pkg::level_t ack_level,  // Level that was taken
  output logic            int_any,
  output cga_pkg::level_t int_level
);

  import cga_pkg::*;

  logic [15:0] pending_q;   // PID, one bit per level
  logic [15:0] enable_q;    // PIE
  logic [15:0] set_vec;     // Lines seen this strobe
  logic [15:0] clr_vec;     // Acknowledged level
  logic [15:0] req_vec;
  level_t      level_enc;

  // Line latch, only sampled in the strobe cycle
  always_comb begin
    set_vec = '0;
    if (aluclk) begin
      set_vec[10] = ~ibint10_n;
      set_vec[11] = ~ibint11_n;
      set_vec[12] = ~ibint12_n;
      set_vec[13] = ~ibint13_n;
      set_vec[15] = ~ibint15_n; // No line for level 14
    end
  end

  // One-hot clear of the acknowledged level
  always_comb begin
    clr_vec = '0;
    if (int_ack) clr_vec[ack_level] = 1'b1;
  end

  // Set wins over clear on the same bit
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_vec) | set_vec;
    end
  end

  // All levels enabled out of reset
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      enable_q <= '1;
    end else if (pie_load) begin
      enable_q <= cd;
    end
  end

  assign req_vec = pending_q & enable_q;

  // Highest set bit wins, scan upwards
  always_comb begin
    level_enc = '0;
    for (int i = 0; i < 16; i++) begin
      if (req_vec[i]) level_enc = level_t'(i);
    end
  end

  assign int_any   = |req_vec;
  assign int_level = level_enc;

  // Sequencer must only acknowledge a level that is really pending
  a_ack_pending : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    int_ack |-> pending_q[ack_level]
  ) else $error("int_ack for level %0d which is not pending", ack_level);

endmodule

//--- source/cga_microword_decode.sv
// ----------------------------------------------------------
// CGA microword decoder
// Registers the control-store word on the ALU strobe and
// reduces it to command, sequencing kind and immediates
// ----------------------------------------------------------
`timescale 1ns/1ps

module cga_microword_decode #(
  parameter int CSA_WIDTH = cga_pkg::csa_width_default
) (
  input  logic                  sysclk,
  input  logic                  rst_n,
  input  logic                  aluclk,      // Word is stable in this cycle
  input  logic [63:0]           csbits,      // Control-store word
  output logic                  word_valid,  // One cycle after the strobe
  output cga_pkg::seq_kind_t    seq_kind,
  output cga_pkg::comm_t        comm,
  output logic [CSA_WIDTH-1:0]  target,      // Jump / vector base
  output logic [15:0]           loop_data    // Immediate field
);

  import cga_pkg::*;

  logic [63:0] word_q;      // Whole microword, ALU fields ride along
  logic        valid_q;
  logic        vect;
  logic        loop;
  logic        scond;
  logic [15:0] data;

  // Payload, held until the next strobe
  always_ff @(posedge sysclk) begin
    if (aluclk) word_q <= csbits;
  end

  // Strobe delayed by one, single-cycle pulse
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= aluclk;
    end
  end

  // Field extraction
  assign vect  = word_q[vect_bit];
  assign loop  = word_q[loop_bit];
  assign scond = word_q[scond_bit];
  assign data  = word_q[data_msb:data_lsb];

  // Codes outside the enum fall through as nop in the sequencer
  assign comm = comm_t'(word_q[comm_msb:comm_lsb]);

  // Vect above loop above scond
  always_comb begin
    if (vect) begin
      seq_kind = seq_vector;
    end else if (loop) begin
      seq_kind = seq_loop;
    end else if (scond) begin
      seq_kind = seq_cond;
    end else begin
      seq_kind = seq_next;
    end
  end

  assign target     = data[CSA_WIDTH-1:0]; // Address part of immediate
  assign loop_data  = data;
  assign word_valid = valid_q;

  // Control word must be fully known when the strobe takes it
  a_word_known : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    aluclk |-> !$isunknown(csbits)
  ) else $error("control word has unknown bits in a strobe cycle");

endmodule

//--- source/cga_pkg.sv
// ----------------------------------------------------------
// CGA shared definitions
// Control-word field positions, command codes, sequencing
// kinds and the interrupt level type
// ----------------------------------------------------------

package cga_pkg;

  // Control-store address width, 8K words
  localparam int csa_width_default = 13;

  // Command field CSCOMM
  localparam int comm_msb = 36;
  localparam int comm_lsb = 32;

  // Single-bit sequencing controls
  localparam int vect_bit  = 25; // CSVECT
  localparam int scond_bit = 24; // CSSCOND
  localparam int loop_bit  = 22; // CSLOOP

  // Immediate field CSBIT_15_0
  localparam int data_msb = 15;
  localparam int data_lsb = 0;

  // Commands handled by this part of the gate array
  // Other codes are ALU work and act as nop here
  typedef enum logic [4:0] {
    comm_nop   = 5'h00,
    comm_ion   = 5'h05, // Interrupt system on
    comm_iof   = 5'h06, // Interrupt system off
    comm_ldcnt = 5'h0c, // Loop counter from immediate
    comm_ldpil = 5'h11  // PIL from immediate 3:0
  } comm_t;

  // Resolved sequencing kind of one microword
  typedef enum logic [1:0] {
    seq_next   = 2'd0,
    seq_vector = 2'd1,
    seq_loop   = 2'd2,
    seq_cond   = 2'd3
  } seq_kind_t;

  // Program interrupt level, 0..15
  typedef logic [3:0] level_t;

endpackage

//--- source/cga_sequencer.sv
// ----------------------------------------------------------
// CGA sequencer
// Next control-store address, loop counter, program
// interrupt level and interrupt-system-on flag
// ----------------------------------------------------------
`timescale 1ns/1ps

module cga_sequencer #(
  parameter int CSA_WIDTH = cga_pkg::csa_width_default
) (
  input  logic                  sysclk,
  input  logic                  rst_n,
  input  logic                  word_valid,  // Decoded word present
  input  cga_pkg::seq_kind_t    seq_kind,
  input  cga_pkg::comm_t        comm,
  input  logic [CSA_WIDTH-1:0]  target,
  input  logic [15:0]           loop_data,
  input  logic                  acond,       // ALU condition level
  input  logic                  int_any,     // Something pending and enabled
  input  cga_pkg::level_t       int_level,   // Highest such level
  output logic                  int_ack,     // Vector taken this cycle
  output cga_pkg::level_t       ack_level,
  output logic [CSA_WIDTH-1:0]  csa,         // Control-store address
  output cga_pkg::level_t       pil,         // Program interrupt level
  output logic                  intrq_n,     // Interrupt request, active low
  output logic                  ioni         // Interrupt system on
);

  import cga_pkg::*;

  logic [CSA_WIDTH-1:0] csa_q;
  logic [CSA_WIDTH-1:0] csa_next;
  logic [CSA_WIDTH-1:0] csa_inc;
  logic [CSA_WIDTH-1:0] csa_vect;
  logic [15:0]          cnt_q;     // Loop counter
  logic [15:0]          cnt_next;
  level_t               pil_q;
  level_t               pil_next;
  logic                 ioni_q;
  logic                 ioni_next;
  logic                 request;
  logic                 vector_take;

  // Request only above the running level
  assign request     = ioni_q && int_any && (int_level > pil_q);
  assign vector_take = word_valid && (seq_kind == seq_vector) && request;

  assign csa_inc  = csa_q + 1'b1;                     // Wraps at width
  assign csa_vect = {target[CSA_WIDTH-1:4], int_level}; // Level into low nibble

  // Address and loop counter
  always_comb begin
    csa_next = csa_q;
    cnt_next = cnt_q;
    if (word_valid) begin
      unique case (seq_kind)
        seq_vector: csa_next = request ? csa_vect : csa_inc;
        seq_loop: begin
          if (cnt_q != '0) begin
            cnt_next = cnt_q - 1'b1;
            csa_next = target;
          end else begin
            csa_next = csa_inc; // Count done, fall through
          end
        end
        seq_cond: csa_next = acond ? target : csa_inc;
        default:  csa_next = csa_inc; // seq_next
      endcase
      if (comm == comm_ldcnt) cnt_next = loop_data; // Load beats decrement
    end
  end

  // Level and interrupt system flag
  always_comb begin
    pil_next  = pil_q;
    ioni_next = ioni_q;
    if (word_valid) begin
      case (comm)
        comm_ion:   ioni_next = 1'b1;
        comm_iof:   ioni_next = 1'b0;
        comm_ldpil: pil_next  = loop_data[3:0];
        default:    ;
      endcase
      if (vector_take) pil_next = int_level; // Vectoring wins over ldpil
    end
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      csa_q  <= '0;
      cnt_q  <= '0;
      pil_q  <= '0;
      ioni_q <= 1'b0;
    end else begin
      csa_q  <= csa_next;
      cnt_q  <= cnt_next;
      pil_q  <= pil_next;
      ioni_q <= ioni_next;
    end
  end

  assign int_ack   = vector_take;
  assign ack_level = int_level;
  assign csa       = csa_q;
  assign pil       = pil_q;
  assign ioni      = ioni_q;
  assign intrq_n   = ~request;

  // Decoded word and interrupt inputs known whenever a word is acted on
  a_word_inputs : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    word_valid |-> !$isunknown({seq_kind, comm, target, loop_data, acond, int_any, int_level})
  ) else $error("decoded word or interrupt inputs unknown while word_valid is high");

endmodule

//--- source/cga_top.sv
// ----------------------------------------------------------
// CGA control top
// Interrupt unit and microword decoder side by side, feeding
// the control-store sequencer
// ----------------------------------------------------------
`timescale 1ns/1ps

module cga_top #(
  parameter int CSA_WIDTH = cga_pkg::csa_width_default
) (
  input  logic                  sysclk,
  input  logic                  rst_n,
  input  logic                  aluclk,     // ALU step strobe
  input  logic [63:0]           csbits,     // Control-store word
  input  logic                  ibint10_n,
  input  logic                  ibint11_n,
  input  logic                  ibint12_n,
  input  logic                  ibint13_n,
  input  logic                  ibint15_n,
  input  logic [15:0]           cd,         // Command/data bus
  input  logic                  pie_load,   // Enable register load
  input  logic                  acond,      // ALU condition
  output logic [CSA_WIDTH-1:0]  csa,
  output cga_pkg::level_t       pil,
  output logic                  intrq_n,
  output logic                  ioni
);

  import cga_pkg::*;

  // Interrupt unit to sequencer
  logic   int_any;
  level_t int_level;

  // Decoder to sequencer
  logic                 word_valid;
  seq_kind_t            seq_kind;
  comm_t                comm;
  logic [CSA_WIDTH-1:0] target;
  logic [15:0]          loop_data;

  // Sequencer back to interrupt unit
  logic   int_ack;
  level_t ack_level;

  cga_int_unit int_unit_i (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .aluclk    (aluclk),
    .ibint10_n (ibint10_n),
    .ibint11_n (ibint11_n),
    .ibint12_n (ibint12_n),
    .ibint13_n (ibint13_n),
    .ibint15_n (ibint15_n),
    .cd        (cd),
    .pie_load  (pie_load),
    .int_ack   (int_ack),
    .ack_level (ack_level),
    .int_any   (int_any),
    .int_level (int_level)
  );

  cga_microword_decode #(
    .CSA_WIDTH (CSA_WIDTH)
  ) decode_i (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .aluclk     (aluclk),
    .csbits     (csbits),
    .word_valid (word_valid),
    .seq_kind   (seq_kind),
    .comm       (comm),
    .target     (target),
    .loop_data  (loop_data)
  );

  // Two sysclk behind the strobe
  cga_sequencer #(
    .CSA_WIDTH (CSA_WIDTH)
  ) sequencer_i (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .word_valid (word_valid),
    .seq_kind   (seq_kind),
    .comm       (comm),
    .target     (target),
    .loop_data  (loop_data),
    .acond      (acond),
    .int_any    (int_any),
    .int_level  (int_level),
    .int_ack    (int_ack),
    .ack_level  (ack_level),
    .csa        (csa),
    .pil        (pil),
    .intrq_n    (intrq_n),
    .ioni       (ioni)
  );

endmodule

//--- verification/cga_stimulus.txt
# name csbits(hex) int_n(bin, levels 15 13 12 11 10) cd(hex) pie_load acond
#   then expected after the step: csa(hex) pil(hex) intrq_n ioni
next_a     0000000000000000 11111 0000 0 0 001 0 1 0
next_b     0000000000000000 11111 0000 0 0 002 0 1 0
cond_hi    000000000100000e 11111 0000 0 1 00e 0 1 0
next_c     0000000000000000 11111 0000 0 0 00f 0 1 0
next_wrap  0000000000000000 11111 0000 0 0 010 0 1 0
cond_lo    0000000001000100 11111 0000 0 0 011 0 1 0
cond_jump  0000000001000100 11111 0000 0 1 100 0 1 0
ldcnt_3    0000000c00000003 11111 0000 0 0 101 0 1 0
loop_1     0000000000400120 11111 0000 0 0 120 0 1 0
loop_2     0000000000400120 11111 0000 0 0 120 0 1 0
loop_3     0000000000400120 11111 0000 0 0 120 0 1 0
loop_exit  0000000000400120 11111 0000 0 0 121 0 1 0
ion_on     0000000500000000 11111 0000 0 0 122 0 1 1
irq13_on   0000000000000000 10111 0000 0 0 123 0 0 1
iof_mask   0000000600000000 11111 0000 0 0 124 0 1 0
pie_mask13 0000000500000000 11111 dfff 1 0 125 0 1 1
irq_11_15  0000000000000000 01101 0000 0 0 126 0 0 1
vect_15    0000000002000300 11111 0000 0 0 30f f 1 1
vect_held  0000000002000300 11111 0000 0 0 310 f 1 1
ldpil_5    0000001100000005 11111 0000 0 0 311 5 0 1
vect_11    0000000002000300 11111 0000 0 0 30b b 1 1
vect_idle  0000000002000300 11111 0000 0 0 30c b 1 1

//--- verification/cga_tb.sv
// ----------------------------------------------------------
// CGA control testbench
// Replays control words and interrupt lines from the stimulus
// file and checks csa, pil, intrq_n and ioni after each step
// ----------------------------------------------------------
`timescale 1ns/1ps

module cga_tb;

  import cga_pkg::*;

  localparam int CSA_WIDTH  = csa_width_default;
  localparam int CLK_PERIOD = 4;   // ns
  localparam int MAX_LINES  = 64;
  localparam     STIM_FILE  = "verification/cga_stimulus.txt";

  logic                 sysclk;
  logic                 rst_n;
  logic                 aluclk;
  logic [63:0]          csbits;
  logic                 ibint10_n;
  logic                 ibint11_n;
  logic                 ibint12_n;
  logic                 ibint13_n;
  logic                 ibint15_n;
  logic [15:0]          cd;
  logic                 pie_load;
  logic                 acond;
  logic [CSA_WIDTH-1:0] csa;
  level_t               pil;
  logic                 intrq_n;
  logic                 ioni;

  // Stimulus table, one entry per ALU step
  string       name_tab  [MAX_LINES];
  logic [63:0] word_tab  [MAX_LINES];
  logic [4:0]  lines_tab [MAX_LINES]; // Active low, levels 15 13 12 11 10
  logic [15:0] cd_tab    [MAX_LINES];
  logic        pie_tab   [MAX_LINES];
  logic        acond_tab [MAX_LINES];
  logic [15:0] csa_tab   [MAX_LINES]; // Expected once the step is done
  logic [3:0]  pil_tab   [MAX_LINES];
  logic        intrq_tab [MAX_LINES];
  logic        ioni_tab  [MAX_LINES];

  int num_lines;
  int error_count;
  int check_count;
  bit load_done;   // Table ready, watchdog may start

  cga_top #(
    .CSA_WIDTH (CSA_WIDTH)
  ) cga_top_i (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .aluclk    (aluclk),
    .csbits    (csbits),
    .ibint10_n (ibint10_n),
    .ibint11_n (ibint11_n),
    .ibint12_n (ibint12_n),
    .ibint13_n (ibint13_n),
    .ibint15_n (ibint15_n),
    .cd        (cd),
    .pie_load  (pie_load),
    .acond     (acond),
    .csa       (csa),
    .pil       (pil),
    .intrq_n   (intrq_n),
    .ioni      (ioni)
  );

  initial begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
  end

  // Fill the table, skipping notes and blank lines
  task automatic load_stimulus();
    int          fd;
    int          code;
    string       line;
    string       name;
    logic [63:0] word;
    logic [4:0]  int_lines;
    logic [15:0] cd_val;
    logic        pie_val;
    logic        acond_val;
    logic [15:0] exp_csa;
    logic [3:0]  exp_pil;
    logic        exp_intrq;
    logic        exp_ioni;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      error_count++;
      $display("error: cannot open the stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd) && num_lines < MAX_LINES) begin
      line = "";
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2) continue;
      if (line.getc(0) == "#") continue; // Column notes
      code = $sscanf(line, "%s %h %b %h %b %b %h %h %b %b", name, word, int_lines,
                     cd_val, pie_val, acond_val, exp_csa, exp_pil, exp_intrq, exp_ioni);
      if (code != 10) begin
        error_count++;
        $display("error: stimulus line could not be read: %s", line);
      end else begin
        name_tab[num_lines]  = name;
        word_tab[num_lines]  = word;
        lines_tab[num_lines] = int_lines;
        cd_tab[num_lines]    = cd_val;
        pie_tab[num_lines]   = pie_val;
        acond_tab[num_lines] = acond_val;
        csa_tab[num_lines]   = exp_csa;
        pil_tab[num_lines]   = exp_pil;
        intrq_tab[num_lines] = exp_intrq;
        ioni_tab[num_lines]  = exp_ioni;
        num_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string test_name, input string sig,
                             input logic [15:0] expected, input logic [15:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("mismatch %s %s: expected %0h, actual %0h", test_name, sig, expected, actual);
    end
  endtask

  // Strobe cycle, caller sits on a falling edge
  task automatic drive_step(input int idx);
    csbits    = word_tab[idx];
    ibint15_n = lines_tab[idx][4];
    ibint13_n = lines_tab[idx][3];
    ibint12_n = lines_tab[idx][2];
    ibint11_n = lines_tab[idx][1];
    ibint10_n = lines_tab[idx][0];
    cd        = cd_tab[idx];
    pie_load  = pie_tab[idx];
    acond     = acond_tab[idx]; // Held through the decode cycle
    aluclk    = 1'b1;
  endtask

  task automatic check_step(input int idx);
    check_value(name_tab[idx], "csa", csa_tab[idx][CSA_WIDTH-1:0], 16'(csa));
    check_value(name_tab[idx], "pil", 16'(pil_tab[idx]), 16'(pil));
    check_value(name_tab[idx], "intrq_n", 16'(intrq_tab[idx]), 16'(intrq_n));
    check_value(name_tab[idx], "ioni", 16'(ioni_tab[idx]), 16'(ioni));
  endtask

  initial begin
    rst_n     = 1'b0;
    aluclk    = 1'b0;
    csbits    = '0;
    ibint10_n = 1'b1;
    ibint11_n = 1'b1;
    ibint12_n = 1'b1;
    ibint13_n = 1'b1;
    ibint15_n = 1'b1;
    cd        = '0;
    pie_load  = 1'b0;
    acond     = 1'b0;
    num_lines   = 0;
    error_count = 0;
    check_count = 0;
    load_done   = 1'b0;
    load_stimulus();
    if (num_lines == 0) begin
      error_count++;
      $display("error: no stimulus lines were loaded");
    end
    load_done = 1'b1;
    repeat (3) @(posedge sysclk);
    @(negedge sysclk);
    rst_n = 1'b1;
    check_value("reset", "csa", 16'h0000, 16'(csa));
    check_value("reset", "pil", 16'h0000, 16'(pil));
    check_value("reset", "intrq_n", 16'h0001, 16'(intrq_n));
    check_value("reset", "ioni", 16'h0000, 16'(ioni));
    for (int i = 0; i < num_lines; i++) begin
      drive_step(i);
      @(negedge sysclk);
      aluclk   = 1'b0;
      pie_load = 1'b0;
      @(negedge sysclk); // Sequencer updated at the second rising edge
      check_step(i);
    end
    $display("summary: %0d steps, %0d checks, %0d errors", num_lines, check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Eight cycles per step is far above the two that a step takes
  initial begin
    wait (load_done);
    repeat (num_lines * 8 + 100) @(posedge sysclk);
    $display("error: watchdog expired before the stimulus was done");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
